//--- common/ppu_pkg.sv
package ppu_pkg;

	// ****************************************
	// line geometry
	// ****************************************

	localparam int line_pixels = 160; // visible pixels per line.
	localparam int row_pixels = 8; // pixels per fetched tile row.
	localparam int cnt_width = 8;
	localparam int fill_width = $clog2(row_pixels + 1); // holds 0 to 8.

	// ****************************************
	// pixel types
	// ****************************************

	// colour index where 0 is transparent for sprites and blank for background.
	typedef logic [1:0] color_t;

	typedef struct packed {
		color_t color;
	} bg_pix_t;

	typedef struct packed {
		color_t color;
		logic pal; // 0 uses obp0, 1 uses obp1.
		logic prio; // 1 puts the sprite behind a non-zero background.
	} spr_pix_t;

	// bit 7 of each plane is the leftmost pixel.
	typedef struct packed {
		logic [7:0] plane_lo;
		logic [7:0] plane_hi;
	} tile_row_t;

	typedef struct packed {
		logic pal;
		logic xflip;
		logic prio;
	} spr_attr_t;

	// shade for colour c sits at bits 2c+1:2c of each palette.
	typedef struct packed {
		logic bg_en;
		logic obj_en;
		logic [7:0] bgp;
		logic [7:0] obp0;
		logic [7:0] obp1;
	} lcd_regs_t;

endpackage

//--- logic/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl (
	input  logic clkpipe,
	input  logic arst_n,
	input  logic line_start,
	input  logic spr_load,
	output logic bg_req,
	output logic spr_take,
	output logic shift,
	output logic emit,
	output logic line_done
);

	logic active; // line in progress.
	logic [ppu_pkg::fill_width-1:0] bg_left; // background pixels still in the shifter.
	logic [ppu_pkg::cnt_width-1:0] pix_cnt; // pixels shifted out this line.
	logic last_pend; // last pixel is on its way through the mixer.
	logic done_q;
	logic last_shift;

	// ****************************************
	// cycle decode
	// ****************************************

	assign bg_req = active && (bg_left == '0);
	assign spr_take = active && !bg_req && spr_load; // sprite merge stalls the pipe.
	assign shift = active && !bg_req && !spr_take;
	assign emit = shift;
	assign line_done = done_q;

	assign last_shift = shift && (pix_cnt == ppu_pkg::cnt_width'(ppu_pkg::line_pixels - 1));

	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			bg_left <= '0;
			pix_cnt <= '0;
			last_pend <= 1'b0;
			done_q <= 1'b0;
		end else begin
			last_pend <= last_shift;
			done_q <= last_pend; // one cycle behind the last pix_valid.
			if (line_start) begin
				active <= 1'b1;
				bg_left <= '0;
				pix_cnt <= '0;
			end else if (bg_req) begin
				bg_left <= ppu_pkg::fill_width'(ppu_pkg::row_pixels);
			end else if (shift) begin
				bg_left <= bg_left - 1'b1;
				pix_cnt <= pix_cnt + 1'b1;
				if (last_shift) begin
					active <= 1'b0;
				end
			end
		end
	end

	// ****************************************
	// checks
	// ****************************************

	// the fill count runs in step with the pixel count, so a shift never finds the row empty.
	a_shift_has_bg: assert property (@(posedge clkpipe) disable iff (!arst_n)
		shift |-> (bg_left == ppu_pkg::fill_width'(ppu_pkg::row_pixels
			- pix_cnt % ppu_pkg::row_pixels)));

	// a merge cycle neither refills nor shifts.
	a_take_stalls: assert property (@(posedge clkpipe) disable iff (!arst_n)
		spr_take && !line_start |=> $stable(bg_left) && $stable(pix_cnt));

endmodule

//--- logic/pixel_shifter.sv
`timescale 1ns/1ps

module pixel_shifter #(
	parameter type pix_t = ppu_pkg::bg_pix_t
) (
	input  logic clkpipe,
	input  logic arst_n,
	input  logic clear,
	input  logic load,
	input  logic [ppu_pkg::row_pixels-1:0] load_mask,
	input  pix_t [ppu_pkg::row_pixels-1:0] load_data,
	input  logic shift,
	output pix_t [ppu_pkg::row_pixels-1:0] slots
);

	// ****************************************
	// slot register
	// ****************************************

	// slot 0 is the next pixel out and an all-zero slot is transparent.
	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			slots <= '0;
		end else if (clear) begin
			slots <= '0; // new line with nothing pending.
		end else if (load) begin
			for (int i = 0; i < ppu_pkg::row_pixels; i++) begin
				if (load_mask[i]) begin
					slots[i] <= load_data[i];
				end
			end
		end else if (shift) begin
			for (int i = 0; i < ppu_pkg::row_pixels - 1; i++) begin
				slots[i] <= slots[i + 1];
			end
			slots[ppu_pkg::row_pixels - 1] <= '0; // fill with transparent.
		end
	end

	// merge and refill cycles never shift.
	a_load_no_shift: assert property (@(posedge clkpipe) disable iff (!arst_n)
		!(load && shift));

endmodule

//--- sprite/sprite_merge.sv
`timescale 1ns/1ps

module sprite_merge (
	input  ppu_pkg::tile_row_t spr_row,
	input  ppu_pkg::spr_attr_t spr_attr,
	input  logic obj_en,
	input  ppu_pkg::spr_pix_t [ppu_pkg::row_pixels-1:0] cur_slots,
	output ppu_pkg::spr_pix_t [ppu_pkg::row_pixels-1:0] load_data,
	output logic [ppu_pkg::row_pixels-1:0] load_mask
);

	ppu_pkg::color_t [ppu_pkg::row_pixels-1:0] new_col;

	// ****************************************
	// row decode
	// ****************************************

	always_comb begin
		logic [2:0] src;
		for (int i = 0; i < ppu_pkg::row_pixels; i++) begin
			// plain order takes bit 7 into slot 0.
			if (spr_attr.xflip) begin
				src = 3'(i);
			end else begin
				src = 3'(ppu_pkg::row_pixels - 1 - i);
			end
			new_col[i] = {spr_row.plane_hi[src], spr_row.plane_lo[src]};
		end
	end

	// ****************************************
	// payload and load gating
	// ****************************************

	always_comb begin
		for (int i = 0; i < ppu_pkg::row_pixels; i++) begin
			load_data[i].color = new_col[i];
			load_data[i].pal = spr_attr.pal;
			load_data[i].prio = spr_attr.prio;
			// an earlier sprite keeps its opaque pixels.
			load_mask[i] = obj_en && (cur_slots[i].color == '0) && (new_col[i] != '0);
		end
	end

endmodule

//--- logic/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer (
	input  logic clkpipe,
	input  logic arst_n,
	input  logic emit,
	input  ppu_pkg::bg_pix_t bg,
	input  ppu_pkg::spr_pix_t spr,
	input  ppu_pkg::lcd_regs_t regs,
	output logic pix_valid,
	output logic [1:0] pix_shade
);

	ppu_pkg::color_t bg_col;
	ppu_pkg::color_t win_col;
	logic spr_win;
	logic [7:0] pal_sel;
	logic [1:0] shade;

	// ****************************************
	// priority and palette
	// ****************************************

	assign bg_col = regs.bg_en ? bg.color : '0; // background off reads as colour 0.

	// prio only hides the sprite behind an opaque background.
	assign spr_win = regs.obj_en && (spr.color != '0) && !(spr.prio && (bg_col != '0));

	always_comb begin
		if (spr_win) begin
			win_col = spr.color;
			pal_sel = spr.pal ? regs.obp1 : regs.obp0;
		end else begin
			win_col = bg_col;
			pal_sel = regs.bgp;
		end
		shade = pal_sel[{win_col, 1'b0} +: 2];
	end

	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= emit;
		end
	end

	always_ff @(posedge clkpipe) begin
		if (emit) begin
			pix_shade <= shade; // holds between pixels.
		end
	end

endmodule

//--- logic/pixel_pipe_top.sv
`timescale 1ns/1ps

module pixel_pipe_top (
	input  logic clkpipe,
	input  logic arst_n,
	input  logic line_start,
	input  ppu_pkg::tile_row_t bg_row,
	input  logic spr_load,
	input  ppu_pkg::tile_row_t spr_row,
	input  ppu_pkg::spr_attr_t spr_attr,
	input  ppu_pkg::lcd_regs_t regs,
	output logic bg_req,
	output logic pix_valid,
	output logic [1:0] pix_shade,
	output logic line_done
);

	logic spr_take;
	logic shift;
	logic emit;
	ppu_pkg::bg_pix_t [ppu_pkg::row_pixels-1:0] bg_load_data;
	ppu_pkg::bg_pix_t [ppu_pkg::row_pixels-1:0] bg_slots;
	ppu_pkg::spr_pix_t [ppu_pkg::row_pixels-1:0] spr_load_data;
	ppu_pkg::spr_pix_t [ppu_pkg::row_pixels-1:0] spr_slots;
	logic [ppu_pkg::row_pixels-1:0] spr_load_mask;

	// leftmost pixel of the row goes to slot 0.
	always_comb begin
		for (int i = 0; i < ppu_pkg::row_pixels; i++) begin
			bg_load_data[i].color = {bg_row.plane_hi[ppu_pkg::row_pixels - 1 - i],
				bg_row.plane_lo[ppu_pkg::row_pixels - 1 - i]};
		end
	end

	pipe_ctrl i_pipe_ctrl (
		.clkpipe(clkpipe), .arst_n(arst_n), .line_start(line_start), .spr_load(spr_load),
		.bg_req(bg_req), .spr_take(spr_take), .shift(shift), .emit(emit),
		.line_done(line_done));

	pixel_shifter #(.pix_t(ppu_pkg::bg_pix_t)) i_bg_shifter (
		.clkpipe(clkpipe), .arst_n(arst_n), .clear(1'b0), .load(bg_req),
		.load_mask('1), .load_data(bg_load_data), .shift(shift), .slots(bg_slots));

	pixel_shifter #(.pix_t(ppu_pkg::spr_pix_t)) i_spr_shifter (
		.clkpipe(clkpipe), .arst_n(arst_n), .clear(line_start), .load(spr_take),
		.load_mask(spr_load_mask), .load_data(spr_load_data), .shift(shift),
		.slots(spr_slots));

	sprite_merge i_sprite_merge (
		.spr_row(spr_row), .spr_attr(spr_attr), .obj_en(regs.obj_en),
		.cur_slots(spr_slots), .load_data(spr_load_data), .load_mask(spr_load_mask));

	pixel_mixer i_pixel_mixer (
		.clkpipe(clkpipe), .arst_n(arst_n), .emit(emit), .bg(bg_slots[0]),
		.spr(spr_slots[0]), .regs(regs), .pix_valid(pix_valid), .pix_shade(pix_shade));

endmodule

//--- tb/tb_pixel_pipe.sv
`timescale 1ns/1ps

module tb_pixel_pipe;

	localparam int num_lines = 6;
	// pixels, refills, sprite stalls and idle cycles per line.
	localparam int timeout_cycles = num_lines * (ppu_pkg::line_pixels + 20 + 40 + 10);

	logic clkpipe;
	logic arst_n;
	logic line_start;
	ppu_pkg::tile_row_t bg_row;
	logic spr_load;
	ppu_pkg::tile_row_t spr_row;
	ppu_pkg::spr_attr_t spr_attr;
	ppu_pkg::lcd_regs_t regs;
	logic bg_req;
	logic pix_valid;
	logic [1:0] pix_shade;
	logic line_done;

	integer seed = 32'he4b8_734b;
	int cycle_cnt = 0;
	int pix_count = 0;
	int lines_seen = 0;

	// ****************************************
	// reference model state
	// ****************************************

	logic m_active;
	int m_left; // background pixels left.
	int m_cnt; // pixels emitted this line.
	logic m_valid;
	logic m_pend;
	logic m_done;
	ppu_pkg::color_t m_bg [8];
	ppu_pkg::spr_pix_t m_spr [8];
	logic [1:0] exp_q [$];

	pixel_pipe_top i_dut (
		.clkpipe(clkpipe), .arst_n(arst_n), .line_start(line_start), .bg_row(bg_row),
		.spr_load(spr_load), .spr_row(spr_row), .spr_attr(spr_attr), .regs(regs),
		.bg_req(bg_req), .pix_valid(pix_valid), .pix_shade(pix_shade),
		.line_done(line_done));

	initial begin
		clkpipe = 1'b0;
		forever #5 clkpipe = ~clkpipe;
	end

	always @(posedge clkpipe) begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_cycles) begin
			$display("Simulation failed");
			$fatal(1, "timeout after %0d cycles without finishing all lines", cycle_cnt);
		end
	end

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// pos counts from the left edge of the row.
	function automatic ppu_pkg::color_t row_pixel(ppu_pkg::tile_row_t row, int pos);
		return {row.plane_hi[7 - pos], row.plane_lo[7 - pos]};
	endfunction

	function automatic logic [1:0] model_shade(ppu_pkg::lcd_regs_t r,
		ppu_pkg::color_t bg_in, ppu_pkg::spr_pix_t s);
		ppu_pkg::color_t bgc;
		ppu_pkg::color_t col;
		logic [7:0] pal;
		logic [7:0] shifted;
		bgc = r.bg_en ? bg_in : 2'd0;
		if (r.obj_en && s.color != '0 && !(s.prio && bgc != '0)) begin
			pal = s.pal ? r.obp1 : r.obp0;
			col = s.color;
		end else begin
			pal = r.bgp;
			col = bgc;
		end
		shifted = pal >> (2 * col);
		return shifted[1:0];
	endfunction

	// one clock edge of the model, using the inputs just driven.
	task automatic model_step();
		logic req;
		logic take;
		logic shf;
		ppu_pkg::color_t c;
		req = m_active && (m_left == 0);
		take = m_active && !req && spr_load;
		shf = m_active && !req && !take;
		m_done = m_pend;
		m_pend = shf && (m_cnt == ppu_pkg::line_pixels - 1);
		m_valid = shf;
		if (shf) exp_q.push_back(model_shade(regs, m_bg[0], m_spr[0]));
		if (line_start) begin
			m_active = 1'b1;
			m_left = 0;
			m_cnt = 0;
			for (int i = 0; i < 8; i++) m_spr[i] = '0;
		end else if (req) begin
			for (int i = 0; i < 8; i++) m_bg[i] = row_pixel(bg_row, i);
			m_left = 8;
		end else if (take) begin
			for (int i = 0; i < 8; i++) begin
				c = row_pixel(spr_row, spr_attr.xflip ? 7 - i : i);
				if (regs.obj_en && m_spr[i].color == '0 && c != '0) begin
					m_spr[i].color = c; // only transparent slots take the new sprite.
					m_spr[i].pal = spr_attr.pal;
					m_spr[i].prio = spr_attr.prio;
				end
			end
		end else if (shf) begin
			for (int i = 0; i < 7; i++) begin
				m_bg[i] = m_bg[i + 1];
				m_spr[i] = m_spr[i + 1];
			end
			m_bg[7] = '0;
			m_spr[7] = '0;
			m_left--;
			m_cnt++;
			if (m_cnt == ppu_pkg::line_pixels) m_active = 1'b0;
		end
	endtask

	task automatic check_outputs();
		logic [1:0] exp_shade;
		check_val("bg_req", 32'(bg_req), 32'(m_active && m_left == 0));
		check_val("pix_valid", 32'(pix_valid), 32'(m_valid));
		check_val("line_done", 32'(line_done), 32'(m_done));
		if (pix_valid) begin
			exp_shade = exp_q.pop_front();
			check_val("pix_shade", 32'(pix_shade), 32'(exp_shade));
			pix_count++;
		end
		if (line_done) begin
			check_val("pix_valid count", pix_count, ppu_pkg::line_pixels);
			pix_count = 0;
			lines_seen++;
		end
	endtask

	task automatic run_cycle(input logic start, input logic spr_ok);
		logic [31:0] rnd;
		@(negedge clkpipe);
		check_outputs();
		line_start = start;
		rnd = $random(seed);
		bg_row = ppu_pkg::tile_row_t'(rnd[15:0]);
		spr_row = ppu_pkg::tile_row_t'(rnd[31:16]);
		rnd = $random(seed);
		spr_attr = ppu_pkg::spr_attr_t'(rnd[2:0]);
		spr_load = spr_ok && ((rnd[31:8] % 6) == 0); // roughly one cycle in six.
		model_step();
	endtask

	// ****************************************
	// stimulus
	// ****************************************

	initial begin
		logic [31:0] rnd;
		arst_n = 1'b0;
		line_start = 1'b0;
		bg_row = '0;
		spr_load = 1'b0;
		spr_row = '0;
		spr_attr = '0;
		regs = '0;
		m_active = 1'b0;
		m_left = 0;
		m_cnt = 0;
		m_valid = 1'b0;
		m_pend = 1'b0;
		m_done = 1'b0;
		for (int i = 0; i < 8; i++) begin
			m_bg[i] = '0;
			m_spr[i] = '0;
		end
		repeat (3) @(negedge clkpipe);
		arst_n = 1'b1;
		repeat (4) run_cycle(1'b0, 1'b1); // stray sprite strobes before any line.
		for (int ln = 0; ln < num_lines; ln++) begin
			rnd = $random(seed);
			regs.bgp = rnd[7:0];
			regs.obp0 = rnd[15:8];
			regs.obp1 = rnd[23:16];
			regs.bg_en = (ln != 1);
			regs.obj_en = (ln >= 2); // first two lines are background only.
			run_cycle(1'b1, 1'b0);
			while (lines_seen == ln) run_cycle(1'b0, ln >= 2);
			repeat (2) run_cycle(1'b0, 1'b1);
		end
		if (exp_q.size() != 0) begin
			$display("Simulation failed");
			$fatal(1, "%0d expected pixels never appeared", exp_q.size());
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

//--- filelist.f
common/ppu_pkg.sv
logic/pipe_ctrl.sv
logic/pixel_shifter.sv
sprite/sprite_merge.sv
logic/pixel_mixer.sv
logic/pixel_pipe_top.sv
tb/tb_pixel_pipe.sv

//--- Makefile
# Verilator flow for the pixel pipeline.

VERILATOR ?= verilator
TOP       ?= tb_pixel_pipe
RTL_TOP   ?= pixel_pipe_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "simulation ended without completing, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
